// File: Bender.yml
package:
  name: me_top

sources:
  - files:
      - source/me_pkg.sv
      - source/me_ctrl.sv
      - source/me_pe_array.sv
      - source/me_min_sad.sv
      - source/me_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_me_top.sv

// File: dv/me_ref_model.svh
`ifndef ME_REF_MODEL_SVH
`define ME_REF_MODEL_SVH

// full search over every candidate in raster order
// the first strictly smaller SAD is kept, so earlier positions win ties
function automatic void model_best_match(output int best_sad,
                                         output int best_row,
                                         output int best_col);
  int sad;
  int diff;
  int s_addr;
  int r_addr;
  best_sad = -1;
  best_row = 0;
  best_col = 0;
  for (int r = 0; r < PeNum; r++) begin
    for (int c = 0; c < PeNum; c++) begin
      sad = 0;
      for (int i = 0; i < RefSize; i++) begin
        for (int j = 0; j < RefSize; j++) begin
          s_addr = (r + i) * SearchSize + c + j;
          r_addr = i * RefSize + j;
          diff   = int'(search_mem[s_addr]) - int'(ref_mem[r_addr]);
          sad   += (diff < 0) ? -diff : diff;
        end
      end
      if ((best_sad < 0) || (sad < best_sad)) begin
        best_sad = sad;
        best_row = r;
        best_col = c;
      end
    end
  end
endfunction

`endif

// File: dv/tb_me_top.sv
module tb_me_top;

  localparam int RefSize     = 4;
  localparam int SearchSize  = 8;
  localparam int PeNum       = SearchSize - RefSize + 1;
  localparam int RefAw       = $clog2(RefSize * RefSize);
  localparam int SearchAw    = $clog2(SearchSize * SearchSize);
  localparam int SadW        = me_pkg::PixelW + $clog2(RefSize * RefSize);
  localparam int PosW        = $clog2(PeNum);
  localparam int ResetCycles = 16;
  localparam int NumTests    = 6;
  localparam int CycleLimit  = NumTests * (PeNum * (RefSize * RefSize + 2) + 10) + ResetCycles;

  // memory fill modes
  localparam int FillRand  = 0;
  localparam int FillConst = 1;
  localparam int FillCopy  = 2; // reference block copied out of the search window

  typedef struct {
    string name;
    int    ref_mode;
    int    ref_value;
    int    search_mode;
    int    search_value;
    int    plant_row;
    int    plant_col;
    bit    hold_start;
    int    exp_sad;  // -1 takes the model value
    int    exp_row;
    int    exp_col;
  } test_t;

  // name, ref mode/value, search mode/value, planted row/col, hold start, sad, row, col
  test_t tests [NumTests] = '{
    '{"exact_match",  FillCopy,  0,   FillRand,  0,  2, 3, 1'b0, 0,   -1, -1},
    '{"uniform",      FillConst, 10,  FillConst, 30, 0, 0, 1'b0, 320, 0,  0},
    '{"random",       FillRand,  0,   FillRand,  0,  0, 0, 1'b0, -1,  -1, -1},
    '{"dark_ref",     FillConst, 0,   FillRand,  0,  0, 0, 1'b0, -1,  -1, -1},
    '{"match_corner", FillCopy,  0,   FillRand,  0,  4, 4, 1'b0, 0,   -1, -1},
    '{"start_held",   FillRand,  0,   FillRand,  0,  0, 0, 1'b1, -1,  -1, -1}
  };

  logic                           clk_i = 1'b0;
  logic                           rst_ni;
  logic                           start_i;
  logic [RefAw-1:0]               ref_raddr;
  me_pkg::pixel_t                 ref_rdata;
  logic [PeNum-1:0][SearchAw-1:0] search_raddr;
  me_pkg::pixel_t [PeNum-1:0]     search_rdata;
  logic                           busy;
  logic                           finish;
  logic [SadW-1:0]                min_sad;
  logic [PosW-1:0]                min_row;
  logic [PosW-1:0]                min_col;

  me_pkg::pixel_t ref_mem [RefSize * RefSize];
  me_pkg::pixel_t search_mem [SearchSize * SearchSize];

  logic [15:0] lfsr_state = 16'd48;
  int          cycle_cnt  = 0;
  int          test_errors;
  int          pass_count = 0;
  int          fail_count = 0;
  string       cur_test;

  `include "me_ref_model.svh"

  always #20 clk_i = ~clk_i;

  me_top #(
    .RefSize    (RefSize),
    .SearchSize (SearchSize)
  ) u_me_top (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .ref_raddr_o    (ref_raddr),
    .ref_rdata_i    (ref_rdata),
    .search_raddr_o (search_raddr),
    .search_rdata_i (search_rdata),
    .busy_o         (busy),
    .finish_o       (finish),
    .min_sad_o      (min_sad),
    .min_row_o      (min_row),
    .min_col_o      (min_col)
  );

  // both memories answer the address of the previous cycle
  always @(posedge clk_i) begin
    ref_rdata <= ref_mem[ref_raddr];
    for (int k = 0; k < PeNum; k++) begin
      search_rdata[k] <= search_mem[search_raddr[k]];
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CycleLimit) begin
      $display("timeout: finish_o never arrived within %0d cycles", CycleLimit);
      $display("tests failed");
      $finish;
    end
  end

  // galois form with taps 16, 14, 13 and 11
  function automatic me_pkg::pixel_t rand_pixel();
    me_pkg::pixel_t px;
    px = '0;
    for (int b = 0; b < me_pkg::PixelW; b++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
      px = {px[me_pkg::PixelW-2:0], lfsr_state[0]}; // one step per bit
    end
    return px;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error %s: %s expected %0d, actual %0d", cur_test, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic report_test();
    if (test_errors == 0) begin
      $display("test %s: ok", cur_test);
      pass_count++;
    end else begin
      $display("test %s: %0d mismatches", cur_test, test_errors);
      fail_count++;
    end
  endtask

  task automatic fill_memories(input test_t t);
    int src;
    for (int a = 0; a < SearchSize * SearchSize; a++) begin
      if (t.search_mode == FillConst) begin
        search_mem[a] = me_pkg::pixel_t'(t.search_value);
      end else begin
        search_mem[a] = rand_pixel();
      end
    end
    for (int i = 0; i < RefSize; i++) begin
      for (int j = 0; j < RefSize; j++) begin
        src = (t.plant_row + i) * SearchSize + t.plant_col + j;
        case (t.ref_mode)
          FillConst: ref_mem[i * RefSize + j] = me_pkg::pixel_t'(t.ref_value);
          FillCopy:  ref_mem[i * RefSize + j] = search_mem[src];
          default:   ref_mem[i * RefSize + j] = rand_pixel();
        endcase
      end
    end
  endtask

  task automatic run_test(input test_t t, input bit after_run);
    int exp_sad;
    int exp_row;
    int exp_col;
    cur_test    = t.name;
    test_errors = 0;
    fill_memories(t);
    model_best_match(exp_sad, exp_row, exp_col);
    if (t.exp_sad >= 0) exp_sad = t.exp_sad;
    if (t.exp_row >= 0) exp_row = t.exp_row;
    if (t.exp_col >= 0) exp_col = t.exp_col;
    if (after_run) begin
      check_value("finish_o held from last run", 1, finish);
    end
    start_i = 1'b1;
    @(negedge clk_i);
    check_value("busy_o after start", 1, busy);
    check_value("finish_o after start", 0, finish); // old result dropped
    while (!finish) @(negedge clk_i);
    check_value("busy_o at finish", 0, busy);
    check_value("min_sad_o", exp_sad, min_sad);
    check_value("min_row_o", exp_row, min_row);
    check_value("min_col_o", exp_col, min_col);
    if (t.hold_start) begin
      repeat (3) begin
        @(negedge clk_i);
        check_value("busy_o with start held", 0, busy);
        check_value("finish_o with start held", 1, finish);
      end
    end
    start_i = 1'b0;
    @(negedge clk_i);
    report_test();
  endtask

  initial begin
    rst_ni       = 1'b0;
    start_i      = 1'b0;
    ref_rdata    = '0;
    search_rdata = '0;
    for (int a = 0; a < RefSize * RefSize; a++) ref_mem[a] = '0;
    for (int a = 0; a < SearchSize * SearchSize; a++) search_mem[a] = '0;
    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    cur_test    = "reset_state";
    test_errors = 0;
    check_value("busy_o", 0, busy);
    check_value("finish_o", 0, finish);
    check_value("min_sad_o", 0, min_sad);
    check_value("min_row_o", 0, min_row);
    check_value("min_col_o", 0, min_col);
    report_test();
    for (int t = 0; t < NumTests; t++) begin
      run_test(tests[t], t > 0); // no reset between runs
    end
    $display("summary: %0d run, %0d passed, %0d failed",
             pass_count + fail_count, pass_count, fail_count);
    if (fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: source/me_ctrl.sv
module me_ctrl #(
  parameter int  RefSize    = 4,
  parameter int  SearchSize = 8,
  localparam int PeNum      = SearchSize - RefSize + 1,
  localparam int RefAw      = (RefSize > 1) ? $clog2(RefSize * RefSize) : 1,
  localparam int SearchAw   = (SearchSize > 1) ? $clog2(SearchSize * SearchSize) : 1,
  localparam int PosW       = (PeNum > 1) ? $clog2(PeNum) : 1
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               start_i,
  output logic [RefAw-1:0]                   ref_raddr_o,
  output logic [PeNum-1:0][SearchAw-1:0]     search_raddr_o,
  output logic                               acc_clear_o,
  output logic                               acc_en_o,
  output logic                               row_valid_o,
  output logic [PosW-1:0]                    cand_row_o,
  output logic                               search_init_o,
  output logic                               busy_o,
  output logic                               finish_o
);

  localparam int RefCw = (RefSize > 1) ? $clog2(RefSize) : 1;

  me_pkg::ctrl_state_e state_q, state_d;

  logic                start_q;
  logic                start_edge;
  logic [PosW-1:0]     cand_row_q, cand_row_d;
  logic [RefCw-1:0]    ref_row_q, ref_row_d;
  logic [RefCw-1:0]    ref_col_q, ref_col_d;
  logic                ref_last;
  logic                busy_d, finish_d;
  logic                scan_q;  // memory data of this cycle belongs to the row
  logic                first_q; // memory data of this cycle is pixel (0,0)
  logic [SearchAw-1:0] search_row_base;

  assign start_edge = start_i & ~start_q & ~busy_o; // ignored while a run is active
  assign ref_last   = (ref_row_q == RefCw'(RefSize - 1)) && (ref_col_q == RefCw'(RefSize - 1));

  always_comb begin
    state_d    = state_q;
    cand_row_d = cand_row_q;
    ref_row_d  = ref_row_q;
    ref_col_d  = ref_col_q;
    busy_d     = busy_o;
    finish_d   = finish_o;
    unique case (state_q)
      me_pkg::IDLE: begin
        if (start_edge) begin
          state_d    = me_pkg::SCAN;
          cand_row_d = '0;
          busy_d     = 1'b1;
          finish_d   = 1'b0; // previous result no longer valid
        end
      end
      me_pkg::SCAN: begin
        if (ref_last) begin
          ref_row_d = '0;
          ref_col_d = '0;
          state_d   = me_pkg::DRAIN;
        end else if (ref_col_q == RefCw'(RefSize - 1)) begin
          ref_col_d = '0;
          ref_row_d = ref_row_q + 1'b1;
        end else begin
          ref_col_d = ref_col_q + 1'b1; // raster order
        end
      end
      me_pkg::DRAIN: begin
        state_d = me_pkg::COMPARE;
      end
      me_pkg::COMPARE: begin
        if (cand_row_q == PosW'(PeNum - 1)) begin
          state_d = me_pkg::DONE;
        end else begin
          cand_row_d = cand_row_q + 1'b1;
          state_d    = me_pkg::SCAN;
        end
      end
      me_pkg::DONE: begin
        state_d  = me_pkg::IDLE;
        busy_d   = 1'b0;
        finish_d = 1'b1; // held in IDLE until the next start
      end
      default: begin
        state_d = me_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= me_pkg::IDLE;
      start_q    <= 1'b0;
      cand_row_q <= '0;
      ref_row_q  <= '0;
      ref_col_q  <= '0;
      busy_o     <= 1'b0;
      finish_o   <= 1'b0;
      scan_q     <= 1'b0;
      first_q    <= 1'b0;
    end else begin
      state_q    <= state_d;
      start_q    <= start_i;
      cand_row_q <= cand_row_d;
      ref_row_q  <= ref_row_d;
      ref_col_q  <= ref_col_d;
      busy_o     <= busy_d;
      finish_o   <= finish_d;
      // memories answer one cycle after the address
      scan_q     <= (state_q == me_pkg::SCAN);
      first_q    <= (state_q == me_pkg::SCAN) && (ref_row_q == '0) && (ref_col_q == '0);
    end
  end

  // reference block is read in raster order
  assign ref_raddr_o = RefAw'(int'(ref_row_q) * RefSize + int'(ref_col_q));

  // lane k looks at candidate column k of the current candidate row
  always_comb begin
    search_row_base = SearchAw'((int'(cand_row_q) + int'(ref_row_q)) * SearchSize);
    for (int k = 0; k < PeNum; k++) begin
      search_raddr_o[k] = search_row_base + SearchAw'(k) + SearchAw'(ref_col_q);
    end
  end

  assign acc_en_o      = scan_q;
  assign acc_clear_o   = first_q;
  assign row_valid_o   = (state_q == me_pkg::COMPARE);
  assign cand_row_o    = cand_row_q;
  assign search_init_o = start_edge;

endmodule

// File: source/me_min_sad.sv
module me_min_sad #(
  parameter int  RefSize    = 4,
  parameter int  SearchSize = 8,
  localparam int PeNum      = SearchSize - RefSize + 1,
  localparam int SadW       = me_pkg::PixelW + $clog2(RefSize * RefSize),
  localparam int PosW       = (PeNum > 1) ? $clog2(PeNum) : 1
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               search_init_i,
  input  logic                               row_valid_i,
  input  logic [PosW-1:0]                    cand_row_i,
  input  logic [PeNum-1:0][SadW-1:0]         pe_sad_i,
  output logic [SadW-1:0]                    min_sad_o,
  output logic [PosW-1:0]                    min_row_o,
  output logic [PosW-1:0]                    min_col_o
);

  logic [SadW-1:0] row_min;
  logic [PosW-1:0] row_min_col;
  logic            first_row; // no candidate row seen since search_init

  // strict compare keeps the lowest column on ties
  always_comb begin
    row_min     = pe_sad_i[0];
    row_min_col = '0;
    for (int k = 1; k < PeNum; k++) begin
      if (pe_sad_i[k] < row_min) begin
        row_min     = pe_sad_i[k];
        row_min_col = PosW'(k);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      first_row <= 1'b0;
      min_sad_o <= '0;
      min_row_o <= '0;
      min_col_o <= '0;
    end else if (search_init_i) begin
      first_row <= 1'b1;
      min_sad_o <= '0;
      min_row_o <= '0;
      min_col_o <= '0;
    end else if (row_valid_i) begin
      first_row <= 1'b0;
      if (first_row || (row_min < min_sad_o)) begin // earlier row wins ties
        min_sad_o <= row_min;
        min_row_o <= cand_row_i;
        min_col_o <= row_min_col;
      end
    end
  end

endmodule

// File: source/me_pe_array.sv
module me_pe_array #(
  parameter int  RefSize    = 4,
  parameter int  SearchSize = 8,
  localparam int PeNum      = SearchSize - RefSize + 1,
  localparam int SadW       = me_pkg::PixelW + $clog2(RefSize * RefSize)
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               acc_clear_i,
  input  logic                               acc_en_i,
  input  me_pkg::pixel_t                     ref_pixel_i,
  input  me_pkg::pixel_t [PeNum-1:0]         search_pixel_i,
  output logic [PeNum-1:0][SadW-1:0]         pe_sad_o
);

  me_pkg::pixel_t [PeNum-1:0] abs_diff;

  // same reference pixel goes to every lane
  always_comb begin
    for (int k = 0; k < PeNum; k++) begin
      if (search_pixel_i[k] > ref_pixel_i) begin
        abs_diff[k] = search_pixel_i[k] - ref_pixel_i;
      end else begin
        abs_diff[k] = ref_pixel_i - search_pixel_i[k];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pe_sad_o <= '0;
    end else if (acc_en_i) begin
      for (int k = 0; k < PeNum; k++) begin
        if (acc_clear_i) begin
          pe_sad_o[k] <= SadW'(abs_diff[k]); // first pixel of a candidate row
        end else begin
          pe_sad_o[k] <= pe_sad_o[k] + SadW'(abs_diff[k]);
        end
      end
    end
  end

endmodule

// File: source/me_pkg.sv
package me_pkg;

  // grayscale pixel depth
  localparam int PixelW = 8;

  typedef logic [PixelW-1:0] pixel_t;

  // sequencer states with one candidate row per SCAN/DRAIN/COMPARE round
  typedef enum logic [2:0] {
    IDLE,     // waiting for a start edge
    SCAN,     // stepping through the reference block
    DRAIN,    // last pixel still coming back from memory
    COMPARE,  // row sums ready for the minimum tracker
    DONE      // result final, busy drops next
  } ctrl_state_e;

endpackage

// File: source/me_top.sv
module me_top #(
  parameter int  RefSize    = 4,
  parameter int  SearchSize = 8,
  localparam int PeNum      = SearchSize - RefSize + 1,
  localparam int RefAw      = (RefSize > 1) ? $clog2(RefSize * RefSize) : 1,
  localparam int SearchAw   = (SearchSize > 1) ? $clog2(SearchSize * SearchSize) : 1,
  localparam int SadW       = me_pkg::PixelW + $clog2(RefSize * RefSize),
  localparam int PosW       = (PeNum > 1) ? $clog2(PeNum) : 1
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               start_i,
  output logic [RefAw-1:0]                   ref_raddr_o,
  input  me_pkg::pixel_t                     ref_rdata_i,
  output logic [PeNum-1:0][SearchAw-1:0]     search_raddr_o,
  input  me_pkg::pixel_t [PeNum-1:0]         search_rdata_i,
  output logic                               busy_o,
  output logic                               finish_o,
  output logic [SadW-1:0]                    min_sad_o,
  output logic [PosW-1:0]                    min_row_o,
  output logic [PosW-1:0]                    min_col_o
);

  logic                       acc_clear;
  logic                       acc_en;
  logic                       row_valid;
  logic                       search_init;
  logic [PosW-1:0]            cand_row;
  logic [PeNum-1:0][SadW-1:0] pe_sad; // one SAD per candidate column

  me_ctrl #(
    .RefSize    (RefSize),
    .SearchSize (SearchSize)
  ) u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .ref_raddr_o    (ref_raddr_o),
    .search_raddr_o (search_raddr_o),
    .acc_clear_o    (acc_clear),
    .acc_en_o       (acc_en),
    .row_valid_o    (row_valid),
    .cand_row_o     (cand_row),
    .search_init_o  (search_init),
    .busy_o         (busy_o),
    .finish_o       (finish_o)
  );

  me_pe_array #(
    .RefSize    (RefSize),
    .SearchSize (SearchSize)
  ) u_pe_array (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .acc_clear_i    (acc_clear),
    .acc_en_i       (acc_en),
    .ref_pixel_i    (ref_rdata_i),    // broadcast to all lanes
    .search_pixel_i (search_rdata_i),
    .pe_sad_o       (pe_sad)
  );

  me_min_sad #(
    .RefSize    (RefSize),
    .SearchSize (SearchSize)
  ) u_min_sad (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .search_init_i (search_init),
    .row_valid_i   (row_valid),
    .cand_row_i    (cand_row),
    .pe_sad_i      (pe_sad),
    .min_sad_o     (min_sad_o),
    .min_row_o     (min_row_o),
    .min_col_o     (min_col_o)
  );

endmodule

// File: src.f
+incdir+dv
source/me_pkg.sv
source/me_ctrl.sv
source/me_pe_array.sv
source/me_min_sad.sv
source/me_top.sv
dv/tb_me_top.sv
